// ==== ahb_pkg.sv ====
/*
  AHB-lite bus definitions for the memory controller.
  Holds the bus widths and the transfer type and size codes.
*/

package ahb_pkg;

  localparam int haddr_w = 14; // byte address reaching the memory
  localparam int hdata_w = 128;

  typedef enum logic [1:0]
  {
    idle   = 2'b00,
    busy   = 2'b01,
    nonseq = 2'b10,
    seq    = 2'b11
  } htrans_t;

  // codes 5 to 7 are reserved and write nothing
  typedef enum logic [2:0]
  {
    size_byte  = 3'd0,
    size_hword = 3'd1,
    size_word  = 3'd2,
    size_dword = 3'd3,
    size_qword = 3'd4
  } hsize_t;

endpackage

// ==== mem_pkg.sv ====
/*
  Lane memory geometry.
  Sixteen byte lanes form one row, and the lane decode maps a
  transfer size and lane offset onto the lanes it touches.
*/

package mem_pkg;

  import ahb_pkg::*;

  localparam int lane_count = 16;
  localparam int lane_w     = 8;
  localparam int lane_sel_w = 4;
  localparam int row_w      = haddr_w - lane_sel_w;
  localparam int row_count  = 1 << row_w;

  typedef logic [lane_count-1:0] lane_mask_t;

  function automatic lane_mask_t lane_decode(hsize_t size, logic [lane_sel_w-1:0] offset);
    lane_mask_t            base;
    logic [lane_sel_w-1:0] start;
    base  = '0;
    start = offset;
    case (size)
      size_byte:
        base = lane_mask_t'(1);
      size_hword:
      begin
        base  = lane_mask_t'(2'b11);
        start = offset & ~lane_sel_w'(1);
      end
      size_word:
      begin
        base  = lane_mask_t'(4'hf);
        start = offset & ~lane_sel_w'(3);
      end
      size_dword:
      begin
        base  = lane_mask_t'(8'hff);
        start = offset & ~lane_sel_w'(7);
      end
      size_qword:
      begin
        base  = '1;
        start = '0;
      end
      default:
        base = '0; // reserved sizes select no lane
    endcase
    return base << start;
  endfunction

endpackage

// ==== lane_ram.sv ====
/*
  One byte lane of the memory.
  Synchronous write and registered read at the same row address.
*/

`timescale 1ns/1ps

module lane_ram
  import mem_pkg::*;
(
  input  logic              hclk,
  input  logic              we,
  input  logic [row_w-1:0]  row,
  input  logic [lane_w-1:0] din,
  output logic [lane_w-1:0] dout
);

  logic [lane_w-1:0] mem [row_count];

  always_ff @(posedge hclk)
  begin
    if (we)
      mem[row] <= din;
    dout <= mem[row]; // old contents on a same-row write
  end

endmodule

// ==== lane_ram_array.sv ====
/*
  Sixteen byte-wide lane RAMs sharing one row address.
  Registers the lane write enables of the accepted write so the
  RAM is written in the write's data phase.
*/

`timescale 1ns/1ps

module lane_ram_array
  import ahb_pkg::*;
  import mem_pkg::*;
(
  input  logic               hclk,
  input  logic               hrst_b,
  input  logic               trans_write,
  input  lane_mask_t         lane_mask,
  input  logic [row_w-1:0]   ram_row,
  input  logic [hdata_w-1:0] hwdata,
  output logic [hdata_w-1:0] ram_rdata
);

  lane_mask_t lane_we;

  always_ff @(posedge hclk or negedge hrst_b)
  begin
    if (!hrst_b)
      lane_we <= '0;
    else if (trans_write)
      lane_we <= lane_mask;
    else
      lane_we <= '0; // enables last for one data phase only
  end

  for (genvar i = 0; i < lane_count; i++)
  begin : g_lane
    lane_ram u_lane_ram
    (
      .hclk (hclk),
      .we   (lane_we[i]),
      .row  (ram_row),
      .din  (hwdata[i*lane_w +: lane_w]),
      .dout (ram_rdata[i*lane_w +: lane_w])
    );
  end

endmodule

// ==== ahb_addr_phase.sv ====
/*
  AHB-lite address-phase front end.
  Accepts transfers, captures the row and lanes of the accepted
  transfer, inserts the read-after-write wait state and picks the
  row that addresses the lane RAMs.
*/

`timescale 1ns/1ps

module ahb_addr_phase
  import ahb_pkg::*;
  import mem_pkg::*;
(
  input  logic               hclk,
  input  logic               hrst_b,
  input  logic               hsel,
  input  htrans_t            htrans,
  input  logic               hwrite,
  input  hsize_t             hsize,
  input  logic [haddr_w-1:0] haddr,
  input  logic               raw_stall,
  output logic               hready,
  output logic               trans_write,
  output logic               rd_accept,
  output logic               wr_pending,
  output lane_mask_t         lane_mask,
  output lane_mask_t         rd_mask,
  output logic [row_w-1:0]   cap_row,
  output lane_mask_t         cap_mask,
  output logic [row_w-1:0]   ram_row
);

  logic             trans_accept;
  lane_mask_t       size_mask;
  logic [row_w-1:0] live_row;

  assign trans_accept = hsel && hready && ((htrans == nonseq) || (htrans == seq));
  assign trans_write  = trans_accept && hwrite;
  assign rd_accept    = trans_accept && !hwrite;

  assign live_row  = haddr[haddr_w-1:lane_sel_w];
  assign size_mask = lane_decode(hsize, haddr[lane_sel_w-1:0]);

  // the same decode serves both directions, split by hwrite
  assign lane_mask = hwrite ? size_mask : '0;
  assign rd_mask   = hwrite ? '0 : size_mask;

  // a write accepted now has its data phase in the next cycle
  always_ff @(posedge hclk or negedge hrst_b)
  begin
    if (!hrst_b)
      wr_pending <= 1'b0;
    else
      wr_pending <= trans_write;
  end

  // low for one cycle after a read that cannot be bypassed
  always_ff @(posedge hclk or negedge hrst_b)
  begin
    if (!hrst_b)
      hready <= 1'b0;
    else
      hready <= !raw_stall;
  end

  // reads are captured too, so the wait state can re-address the RAM
  always_ff @(posedge hclk or negedge hrst_b)
  begin
    if (!hrst_b)
      cap_row <= '0;
    else if (trans_accept)
      cap_row <= live_row;
  end

  always_ff @(posedge hclk or negedge hrst_b)
  begin
    if (!hrst_b)
      cap_mask <= '0;
    else if (trans_write)
      cap_mask <= lane_mask;
  end

  assign ram_row = (wr_pending || !hready) ? cap_row : live_row;

endmodule

// ==== raw_bypass.sv ====
/*
  Read-after-write handling.
  A read whose address phase meets a write's data phase is served
  from the write data when it stays within the written lanes of
  the same row, and otherwise costs one wait state.
*/

`timescale 1ns/1ps

module raw_bypass
  import ahb_pkg::*;
  import mem_pkg::*;
(
  input  logic               hclk,
  input  logic               hrst_b,
  input  logic               rd_accept,
  input  logic               wr_pending,
  input  logic [haddr_w-1:0] haddr,
  input  lane_mask_t         rd_mask,
  input  logic [row_w-1:0]   cap_row,
  input  lane_mask_t         cap_mask,
  input  logic [hdata_w-1:0] hwdata,
  input  logic [hdata_w-1:0] ram_rdata,
  output logic               raw_stall,
  output logic [hdata_w-1:0] hrdata
);

  logic               raw_hit;
  logic               same_row;
  logic               lane_subset;
  logic               bypass_en;
  logic               byp_vld;
  logic [hdata_w-1:0] fwd_data;

  assign raw_hit     = rd_accept && wr_pending;
  assign same_row    = (haddr[haddr_w-1:lane_sel_w] == cap_row);
  assign lane_subset = ((rd_mask & ~cap_mask) == '0); // every read lane is being written

  assign bypass_en = raw_hit && same_row && lane_subset;
  assign raw_stall = raw_hit && !bypass_en;

  // hwdata here is the data phase of the pending write
  always_ff @(posedge hclk)
  begin
    if (bypass_en)
      fwd_data <= hwdata;
  end

  // the read data phase always follows directly, so one cycle is enough
  always_ff @(posedge hclk or negedge hrst_b)
  begin
    if (!hrst_b)
      byp_vld <= 1'b0;
    else
      byp_vld <= bypass_en;
  end

  assign hrdata = byp_vld ? fwd_data : ram_rdata;

endmodule

// ==== mem_ctrl.sv ====
/*
  AHB-lite slave memory controller, 128-bit data path.
  Joins the address-phase front end, the read-after-write bypass
  and the sixteen-lane RAM array.
*/

`timescale 1ns/1ps

module mem_ctrl
  import ahb_pkg::*;
  import mem_pkg::*;
(
  input  logic               hclk,
  input  logic               hrst_b,
  input  logic               hsel,
  input  htrans_t            htrans,
  input  logic               hwrite,
  input  hsize_t             hsize,
  input  logic [haddr_w-1:0] haddr,
  input  logic [hdata_w-1:0] hwdata,
  output logic [hdata_w-1:0] hrdata,
  output logic               hready
);

  logic               trans_write;
  logic               rd_accept;
  logic               wr_pending;
  logic               raw_stall;
  lane_mask_t         lane_mask;
  lane_mask_t         rd_mask;
  lane_mask_t         cap_mask;
  logic [row_w-1:0]   cap_row;
  logic [row_w-1:0]   ram_row;
  logic [hdata_w-1:0] ram_rdata;

  ahb_addr_phase u_addr_phase
  (
    .hclk        (hclk),
    .hrst_b      (hrst_b),
    .hsel        (hsel),
    .htrans      (htrans),
    .hwrite      (hwrite),
    .hsize       (hsize),
    .haddr       (haddr),
    .raw_stall   (raw_stall),
    .hready      (hready),
    .trans_write (trans_write),
    .rd_accept   (rd_accept),
    .wr_pending  (wr_pending),
    .lane_mask   (lane_mask),
    .rd_mask     (rd_mask),
    .cap_row     (cap_row),
    .cap_mask    (cap_mask),
    .ram_row     (ram_row)
  );

  raw_bypass u_raw_bypass
  (
    .hclk       (hclk),
    .hrst_b     (hrst_b),
    .rd_accept  (rd_accept),
    .wr_pending (wr_pending),
    .haddr      (haddr),
    .rd_mask    (rd_mask),
    .cap_row    (cap_row),
    .cap_mask   (cap_mask),
    .hwdata     (hwdata),
    .ram_rdata  (ram_rdata),
    .raw_stall  (raw_stall),
    .hrdata     (hrdata)
  );

  lane_ram_array u_ram_array
  (
    .hclk        (hclk),
    .hrst_b      (hrst_b),
    .trans_write (trans_write),
    .lane_mask   (lane_mask),
    .ram_row     (ram_row),
    .hwdata      (hwdata),
    .ram_rdata   (ram_rdata)
  );

endmodule

// ==== mem_ctrl_props.sv ====
/*
  Bound checker for the memory controller.
  Keeps a byte shadow of the memory from observed writes and checks
  the read data, the read-after-write wait state and the bypass timing.
*/

`timescale 1ns/1ps

module mem_ctrl_props
  import ahb_pkg::*;
  import mem_pkg::*;
(
  input logic               hclk,
  input logic               hrst_b,
  input logic               hsel,
  input htrans_t            htrans,
  input logic               hwrite,
  input hsize_t             hsize,
  input logic [haddr_w-1:0] haddr,
  input logic [hdata_w-1:0] hwdata,
  input logic [hdata_w-1:0] hrdata,
  input logic               hready
);

  int                 error_count = 0;
  logic [lane_w-1:0]  shadow [row_count][lane_count];
  logic               ready_seen;
  logic               wr_pend;
  logic               rd_pend;
  logic [row_w-1:0]   wr_row;
  logic [row_w-1:0]   rd_row;
  lane_mask_t         wr_lanes;
  lane_mask_t         rd_lanes;
  lane_mask_t         acc_lanes;
  logic [row_w-1:0]   acc_row;
  logic               acc;
  logic               wr_acc;
  logic               rd_acc;
  logic               bypassable;
  logic               conflict;
  logic [hdata_w-1:0] exp_rdata;
  logic [hdata_w-1:0] rd_bits;

  // a transfer of 2**size bytes starts at the offset rounded down to its size
  function automatic lane_mask_t touched_lanes(input logic [2:0] size, input logic [3:0] offset);
    int nbytes;
    int first;
    touched_lanes = '0;
    if (size <= 3'd4)
    begin
      nbytes = 1 << size;
      first  = offset - (offset % nbytes);
      for (int i = 0; i < nbytes; i++)
        touched_lanes[first + i] = 1'b1;
    end
  endfunction

  assign acc        = hsel && hready && ((htrans == nonseq) || (htrans == seq));
  assign wr_acc     = acc && hwrite;
  assign rd_acc     = acc && !hwrite;
  assign acc_row    = haddr[haddr_w-1:lane_sel_w];
  assign acc_lanes  = touched_lanes(hsize, haddr[lane_sel_w-1:0]);
  assign bypassable = rd_acc && wr_pend && (acc_row == wr_row) && ((acc_lanes & ~wr_lanes) == '0);
  assign conflict   = rd_acc && wr_pend && !bypassable;

  always_ff @(posedge hclk or negedge hrst_b)
  begin
    if (!hrst_b)
    begin
      ready_seen <= 1'b0;
      wr_pend    <= 1'b0;
      rd_pend    <= 1'b0;
      wr_row     <= '0;
      wr_lanes   <= '0;
      rd_row     <= '0;
      rd_lanes   <= '0;
    end
    else
    begin
      ready_seen <= 1'b1;
      wr_pend    <= wr_acc; // a write data phase never waits
      if (wr_acc)
      begin
        wr_row   <= acc_row;
        wr_lanes <= acc_lanes;
      end
      if (hready)
        rd_pend <= rd_acc;
      if (rd_acc)
      begin
        rd_row   <= acc_row;
        rd_lanes <= acc_lanes;
      end
    end
  end

  always_ff @(posedge hclk)
  begin
    if (wr_pend)
      for (int i = 0; i < lane_count; i++)
        if (wr_lanes[i])
          shadow[wr_row][i] <= hwdata[i*lane_w +: lane_w];
  end

  always_comb
  begin
    for (int i = 0; i < lane_count; i++)
    begin
      exp_rdata[i*lane_w +: lane_w] = shadow[rd_row][i];
      rd_bits[i*lane_w +: lane_w]   = {lane_w{rd_lanes[i]}};
    end
  end

  a_read_data: assert property (@(posedge hclk) disable iff (!hrst_b)
    rd_pend && hready |-> (hrdata & rd_bits) === (exp_rdata & rd_bits))
  else
  begin
    error_count++;
    $error("MISMATCH hrdata row %h expected %h actual %h", $sampled(rd_row),
      $sampled(exp_rdata & rd_bits), $sampled(hrdata & rd_bits));
  end

  a_one_wait: assert property (@(posedge hclk) disable iff (!hrst_b)
    conflict |=> !hready ##1 hready)
  else
  begin
    error_count++;
    $error("a conflicting read did not see exactly one wait state");
  end

  a_bypass_no_wait: assert property (@(posedge hclk) disable iff (!hrst_b)
    bypassable |=> hready)
  else
  begin
    error_count++;
    $error("MISMATCH hready after bypassable read expected %h actual %h", 1'b1, 1'b0);
  end

  // every wait state must be caused by a conflicting read
  a_wait_cause: assert property (@(posedge hclk) disable iff (!hrst_b)
    ready_seen && !hready |-> $past(conflict))
  else
  begin
    error_count++;
    $error("hready was low without a read-after-write conflict before it");
  end

endmodule

// ==== tb_clock.sv ====
/*
  Clock and reset for the memory controller testbench.
*/

`timescale 1ns/1ps

module tb_clock
(
  output logic hclk,
  output logic hrst_b
);

  localparam int half_period = 20;

  initial
  begin
    hclk = 1'b0;
    forever #half_period hclk = ~hclk;
  end

  initial
  begin
    hrst_b = 1'b0;
    repeat (4) @(posedge hclk);
    hrst_b <= 1'b1;
  end

endmodule

// ==== tb_mem_ctrl.sv ====
/*
  Testbench for the AHB-lite memory controller.
  Fills the memory, runs directed and random transfers and leaves
  the checking to the bound assertions.
*/

`timescale 1ns/1ps

module tb_mem_ctrl
  import ahb_pkg::*;
  import mem_pkg::*;
();

  localparam int clk_period  = 40;
  localparam int rand_count  = 400;
  localparam int xfer_budget = row_count + 64 + rand_count;

  logic               hclk;
  logic               hrst_b;
  logic               hsel;
  htrans_t            htrans;
  logic               hwrite;
  hsize_t             hsize;
  logic [haddr_w-1:0] haddr;
  logic [hdata_w-1:0] hwdata;
  logic [hdata_w-1:0] hrdata;
  logic               hready;
  logic               ready_at_edge = 1'b0;
  logic [hdata_w-1:0] data_q = '0;
  int                 xfer_done = 0;

  tb_clock clk_i
  (
    .hclk   (hclk),
    .hrst_b (hrst_b)
  );

  mem_ctrl dut_i
  (
    .hclk   (hclk),
    .hrst_b (hrst_b),
    .hsel   (hsel),
    .htrans (htrans),
    .hwrite (hwrite),
    .hsize  (hsize),
    .haddr  (haddr),
    .hwdata (hwdata),
    .hrdata (hrdata),
    .hready (hready)
  );

  bind mem_ctrl mem_ctrl_props props_i (.*);

  always @(negedge hclk)
    ready_at_edge <= hready; // stable copy for the next rising edge

  function automatic logic [hdata_w-1:0] rand_data();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  function automatic logic [lane_w-1:0] fill_byte(input logic [haddr_w-1:0] addr);
    return 8'(addr) ^ 8'(addr >> 6) ^ 8'h5a;
  endfunction

  // address phase of one transfer, returning at the edge that ends it
  task automatic xfer(input logic sel, input htrans_t tr, input logic wr, input hsize_t sz,
                      input logic [haddr_w-1:0] addr, input logic [hdata_w-1:0] data);
    hsel   <= sel;
    htrans <= tr;
    hwrite <= wr;
    hsize  <= sz;
    haddr  <= addr;
    hwdata <= data_q; // data phase of the previous transfer
    data_q = data;
    xfer_done++;
    @(posedge hclk);
    while (!ready_at_edge)
      @(posedge hclk);
  endtask

  task automatic write_at(input hsize_t sz, input logic [haddr_w-1:0] addr,
                          input logic [hdata_w-1:0] data);
    xfer(1'b1, nonseq, 1'b1, sz, addr, data);
  endtask

  task automatic read_at(input hsize_t sz, input logic [haddr_w-1:0] addr);
    xfer(1'b1, nonseq, 1'b0, sz, addr, rand_data());
  endtask

  task automatic idle_cycle();
    xfer(1'b0, idle, 1'b0, size_byte, '0, rand_data());
  endtask

  task automatic fill_memory();
    logic [hdata_w-1:0] data;
    for (int r = 0; r < row_count; r++)
    begin
      for (int i = 0; i < lane_count; i++)
        data[i*lane_w +: lane_w] = fill_byte({row_w'(r), lane_sel_w'(i)});
      write_at(size_qword, {row_w'(r), 4'h0}, data);
    end
  endtask

  task automatic sizes_readback();
    logic [row_w-1:0] row;
    logic [3:0]       off;
    for (int s = 0; s <= 4; s++)
    begin
      row = row_w'($urandom);
      off = 4'((1 << s) * ($urandom % (16 >> s)));
      write_at(hsize_t'(s), {row, off}, rand_data());
      idle_cycle();
      read_at(size_qword, {row, 4'h0});
      idle_cycle();
      read_at(hsize_t'(s), {row, off});
    end
  endtask

  task automatic bypass_reads();
    logic [row_w-1:0] row;
    row = row_w'($urandom);
    write_at(size_dword, {row, 4'h8}, rand_data());
    read_at(size_word, {row, 4'hc}); // inside the written lanes
    write_at(size_qword, {row, 4'h0}, rand_data());
    read_at(size_byte, {row, 4'h3});
    idle_cycle();
  endtask

  task automatic conflict_reads();
    logic [row_w-1:0] row;
    row = row_w'($urandom);
    write_at(size_byte, {row, 4'h2}, rand_data());
    read_at(size_hword, {row, 4'h2}); // wider than the write
    write_at(size_word, {row, 4'h4}, rand_data());
    read_at(size_word, {row + 1'b1, 4'h4});
    idle_cycle();
    read_at(size_qword, {row, 4'h0});
  endtask

  task automatic ignored_transfers();
    logic [row_w-1:0] row;
    row = row_w'($urandom);
    xfer(1'b0, nonseq, 1'b1, size_qword, {row, 4'h0}, rand_data());
    xfer(1'b1, idle, 1'b1, size_qword, {row, 4'h0}, rand_data());
    xfer(1'b1, busy, 1'b1, size_qword, {row, 4'h0}, rand_data());
    xfer(1'b1, nonseq, 1'b1, hsize_t'(3'd6), {row, 4'h0}, rand_data());
    idle_cycle();
    read_at(size_qword, {row, 4'h0});
  endtask

  task automatic random_mix();
    logic [row_w-1:0]   base;
    logic               sel;
    htrans_t            tr;
    hsize_t             sz;
    logic [haddr_w-1:0] addr;
    base = row_w'($urandom);
    for (int n = 0; n < rand_count; n++)
    begin
      sel  = ($urandom % 8) != 0;
      tr   = (($urandom % 4) == 0) ? htrans_t'(2'($urandom % 2)) : htrans_t'(2'(2 + $urandom % 2));
      sz   = (($urandom % 10) == 0) ? hsize_t'(3'(5 + $urandom % 3)) : hsize_t'(3'($urandom % 5));
      addr = {base + row_w'($urandom % 4), 4'($urandom)}; // few rows, so conflicts happen often
      xfer(sel, tr, 1'($urandom), sz, addr, rand_data());
    end
  endtask

  task automatic finish_run(input bit timed_out);
    int errs;
    errs = dut_i.props_i.error_count;
    $display("closing report: %0d assertion errors, %0d timeouts, %0d transfers",
      errs, timed_out, xfer_done);
    if ((errs == 0) && !timed_out)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  endtask

  initial
  begin
    void'($urandom(32'hb0ad));
    hsel   = 1'b0;
    htrans = idle;
    hwrite = 1'b0;
    hsize  = size_byte;
    haddr  = '0;
    hwdata = '0;
    wait (hrst_b);
    @(posedge hclk);
    fill_memory();
    sizes_readback();
    bypass_reads();
    conflict_reads();
    ignored_transfers();
    random_mix();
    repeat (3) idle_cycle();
    finish_run(1'b0);
  end

  initial
  begin
    #(clk_period * (3 * xfer_budget + 100));
    $display("timeout: the run did not finish in time, %0d transfers were issued", xfer_done);
    finish_run(1'b1);
  end

endmodule

// ==== files.f ====
ahb_pkg.sv
mem_pkg.sv
lane_ram.sv
lane_ram_array.sv
ahb_addr_phase.sv
raw_bypass.sv
mem_ctrl.sv
mem_ctrl_props.sv
tb_clock.sv
tb_mem_ctrl.sv
